// ==== project.f ====
csr_pkg.sv
csr_decode.sv
mcsr.sv
trap_unit.sv
csr_top.sv
csr_top_asserts.sv
tb_csr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module tb_csr_top -o sim_tb \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// ==== tb_csr_top.sv ====
// testbench for csr_top that runs the CSR, trap and barrier tests against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;

  import csr_pkg::*;

  // six short tests of well under a hundred cycles each plus a wide margin
  localparam int cycle_limit = 2000;

  logic        clk_i;
  logic        reset_i;
  logic        instr_v_i;
  logic [31:0] instr_i;
  logic [21:0] pc_i;
  logic [31:0] rs1_data_i;
  logic        remote_set_i;
  logic        remote_clear_i;
  logic        barsend_i;
  logic        barrier_po_i;
  logic [31:0] cfg_pod_reset_i;
  logic        rd_v_o;
  logic [31:0] rd_data_o;
  logic        barrier_pi_o;
  logic [6:0]  barrier_src_o;
  logic [2:0]  barrier_dest_o;
  logic [31:0] cfg_pod_o;
  logic [5:0]  credit_limit_o;
  logic [21:0] mepc_o;
  logic        trap_o;
  logic [4:0]  trap_cause_o;
  logic [31:0] redirect_pc_o;

  // reference model holds each CSR as its read value
  logic [31:0] model_mstatus;
  logic [31:0] model_mie;
  logic [31:0] model_mip;
  logic [31:0] model_mepc;
  logic [31:0] model_credit;
  logic [31:0] model_pod;
  logic [31:0] model_barcfg;
  logic [31:0] model_pi;

  logic [21:0] next_pc;
  logic [21:0] last_pc;
  string       cur_test;
  int          errors;
  int          checks;
  int          tests_run;
  int          test_errors_start;
  int          cycles;

  csr_top #(
    .pc_width_p             (22),
    .barrier_dirs_p         (7),
    .credit_limit_default_p (32),
    .credit_counter_width_p (6)
  ) DUT (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the cycle limit was reached before the tests finished");
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      csr_addr_mstatus:      return model_mstatus;
      csr_addr_mie:          return model_mie;
      csr_addr_mip:          return model_mip;
      csr_addr_mepc:         return model_mepc;
      csr_addr_credit_limit: return model_credit;
      csr_addr_cfg_pod:      return model_pod;
      csr_addr_barcfg:       return model_barcfg;
      csr_addr_bar_pi:       return model_pi;
      csr_addr_bar_po:       return {31'b0, barrier_po_i};
      default:               return 32'h0;
    endcase
  endfunction

  // bits that a write can change in each CSR
  function automatic logic [31:0] csr_mask(input logic [11:0] addr);
    case (addr)
      csr_addr_mstatus:             return 32'h0000_0088;
      csr_addr_mie, csr_addr_mip:   return 32'h0003_0000;
      csr_addr_mepc:                return 32'h00ff_fffc;
      csr_addr_credit_limit:        return 32'h0000_003f;
      csr_addr_cfg_pod:             return 32'hffff_ffff;
      csr_addr_barcfg:              return 32'h0007_007f;
      csr_addr_bar_pi:              return 32'h0000_0001;
      default:                      return 32'h0;
    endcase
  endfunction

  function automatic logic form_allowed(input logic [11:0] addr, input logic [2:0] f3);
    case (addr)
      csr_addr_mstatus, csr_addr_bar_pi:          return 1'b1;
      csr_addr_mie, csr_addr_mip, csr_addr_mepc:  return ~f3[2];
      csr_addr_credit_limit, csr_addr_cfg_pod,
      csr_addr_barcfg:                            return f3 == funct3_csrrw;
      default:                                    return 1'b0;
    endcase
  endfunction

  // low funct3 bits select write, set or clear
  function automatic logic [31:0] csr_result(input logic [2:0] f3, input logic [31:0] old,
                                             input logic [31:0] operand);
    case (f3[1:0])
      2'b01:   return operand;
      2'b10:   return old | operand;
      2'b11:   return old & ~operand;
      default: return old;
    endcase
  endfunction

  task automatic model_store(input logic [11:0] addr, input logic [31:0] value);
    case (addr)
      csr_addr_mstatus:      model_mstatus = value;
      csr_addr_mie:          model_mie = value;
      csr_addr_mip:          model_mip = value;
      csr_addr_mepc:         model_mepc = value;
      csr_addr_credit_limit: model_credit = value;
      csr_addr_cfg_pod:      model_pod = value;
      csr_addr_barcfg:       model_barcfg = value;
      csr_addr_bar_pi:       model_pi = value;
      default:               model_pi = model_pi;
    endcase
  endtask

  // presents one instruction and returns in its EXE cycle
  task automatic issue(input logic [31:0] word, input logic [31:0] data);
    instr_v_i  = 1'b1;
    instr_i    = word;
    pc_i       = next_pc;
    rs1_data_i = data;
    last_pc    = next_pc;
    next_pc    = next_pc + 22'd1;
    @(negedge clk_i);
    instr_v_i  = 1'b0;
  endtask

  task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr, input logic [4:0] zimm,
                        input logic [31:0] data);
    logic [31:0] old_exp;
    logic [31:0] operand;
    logic        trace_en;
    old_exp  = model_read(addr);
    operand  = f3[2] ? {27'b0, zimm} : data;
    trace_en = model_mie[irq_trace_bit];
    issue({addr, zimm, f3, 5'd1, opcode_system}, data);
    check_value($sformatf("rd_v at %h", addr), 32'h1, {31'b0, rd_v_o});
    check_value($sformatf("read of %h", addr), old_exp, rd_data_o);
    if (form_allowed(addr, f3)) begin
      model_store(addr, csr_result(f3, old_exp, operand) & csr_mask(addr));
    end
    // any executed instruction raises mip.trace while mie.trace is set
    if (trace_en) begin
      model_mip[irq_trace_bit] = 1'b1;
    end
  endtask

  task automatic read_csr(input logic [11:0] addr);
    csr_op(funct3_csrrs, addr, 5'd0, 32'h0);
  endtask

  task automatic wait_trap(input int max_cycles);
    int n;
    n = 0;
    while (!trap_o && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (!trap_o) begin
      $display("%s: no trap was taken within %0d cycles", cur_test, max_cycles);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test          = name;
    test_errors_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("test %-10s %s", cur_test, (errors == test_errors_start) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(37081));
    reset_i         = 1'b1;
    instr_v_i       = 1'b0;
    instr_i         = 32'h0;
    pc_i            = 22'h0;
    rs1_data_i      = 32'h0;
    remote_set_i    = 1'b0;
    remote_clear_i  = 1'b0;
    barsend_i       = 1'b0;
    barrier_po_i    = 1'b0;
    cfg_pod_reset_i = 32'h0005_0003;
    model_mstatus   = 32'h0;
    model_mie       = 32'h0;
    model_mip       = 32'h0;
    model_mepc      = 32'h0;
    model_credit    = 32'd32;
    model_pod       = 32'h0005_0003;
    model_barcfg    = 32'h0;
    model_pi        = 32'h0;
    next_pc         = 22'h100;
    last_pc         = 22'h0;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    start_test("reset");
    check_value("rd_v", 32'h0, {31'b0, rd_v_o});
    check_value("trap", 32'h0, {31'b0, trap_o});
    check_value("credit out", 32'd32, {26'b0, credit_limit_o});
    check_value("pod out", 32'h0005_0003, cfg_pod_o);
    read_csr(csr_addr_mstatus);
    read_csr(csr_addr_mie);
    read_csr(csr_addr_mip);
    read_csr(csr_addr_mepc);
    read_csr(csr_addr_credit_limit);
    read_csr(csr_addr_cfg_pod);
    read_csr(csr_addr_barcfg);
    read_csr(csr_addr_bar_pi);
    read_csr(csr_addr_bar_po);
    finish_test();

    start_test("regforms");
    csr_op(funct3_csrrw, csr_addr_mepc, 5'd2, $urandom);
    csr_op(funct3_csrrs, csr_addr_mepc, 5'd2, $urandom);
    csr_op(funct3_csrrc, csr_addr_mepc, 5'd2, $urandom);
    read_csr(csr_addr_mepc);
    csr_op(funct3_csrrw, csr_addr_mie, 5'd2, $urandom);
    csr_op(funct3_csrrs, csr_addr_mie, 5'd2, $urandom);
    csr_op(funct3_csrrc, csr_addr_mie, 5'd2, $urandom);
    csr_op(funct3_csrrw, csr_addr_mip, 5'd2, $urandom);
    csr_op(funct3_csrrs, csr_addr_mip, 5'd2, $urandom);
    csr_op(funct3_csrrc, csr_addr_mip, 5'd2, $urandom);
    read_csr(csr_addr_mip);
    csr_op(funct3_csrrw, csr_addr_mie, 5'd2, 32'h0);
    csr_op(funct3_csrrw, csr_addr_mip, 5'd2, 32'h0);
    read_csr(csr_addr_mip);
    finish_test();

    start_test("immforms");
    csr_op(funct3_csrrsi, csr_addr_mstatus, 5'd8, 32'h0);
    csr_op(funct3_csrrci, csr_addr_mstatus, 5'd8, 32'h0);
    csr_op(funct3_csrrwi, csr_addr_mstatus, 5'd8, 32'h0);
    csr_op(funct3_csrrwi, csr_addr_mstatus, 5'd0, 32'h0);
    csr_op(funct3_csrrsi, csr_addr_bar_pi, 5'd1, 32'h0);
    csr_op(funct3_csrrci, csr_addr_bar_pi, 5'd1, 32'h0);
    csr_op(funct3_csrrwi, csr_addr_bar_pi, 5'd1, 32'h0);
    read_csr(csr_addr_mstatus);
    read_csr(csr_addr_bar_pi);
    check_value("pi out", model_pi, {31'b0, barrier_pi_o});
    finish_test();

    start_test("remote");
    csr_op(funct3_csrrw, csr_addr_mie, 5'd2, 32'h0001_0000);
    csr_op(funct3_csrrsi, csr_addr_mstatus, 5'd8, 32'h0);
    remote_set_i = 1'b1;
    @(negedge clk_i);
    remote_set_i = 1'b0;
    wait_trap(10);
    check_value("cause", 32'd16, {27'b0, trap_cause_o});
    check_value("vector", trap_vec_remote, redirect_pc_o);
    @(negedge clk_i);
    check_value("mepc out", {10'b0, last_pc + 22'd1}, {10'b0, mepc_o});
    model_mepc    = {8'b0, last_pc + 22'd1, 2'b00};
    model_mstatus = 32'h0000_0080;
    remote_clear_i = 1'b1;
    @(negedge clk_i);
    remote_clear_i = 1'b0;
    read_csr(csr_addr_mstatus);
    read_csr(csr_addr_mepc);
    issue(instr_mret, 32'h0);
    check_value("rd_v on mret", 32'h0, {31'b0, rd_v_o});
    model_mstatus = 32'h0000_0008;
    read_csr(csr_addr_mstatus);
    finish_test();

    start_test("trace");
    csr_op(funct3_csrrw, csr_addr_mie, 5'd2, 32'h0002_0000);
    // a plain addi counts as executed and raises mip.trace
    issue(32'h0000_0013, 32'h0);
    wait_trap(10);
    check_value("cause", 32'd17, {27'b0, trap_cause_o});
    check_value("vector", trap_vec_trace, redirect_pc_o);
    @(negedge clk_i);
    check_value("mepc out", {10'b0, last_pc + 22'd1}, {10'b0, mepc_o});
    model_mepc    = {8'b0, last_pc + 22'd1, 2'b00};
    model_mstatus = 32'h0000_0080;
    model_mip     = 32'h0002_0000;
    read_csr(csr_addr_mstatus);
    read_csr(csr_addr_mip);
    csr_op(funct3_csrrw, csr_addr_mie, 5'd2, 32'h0);
    csr_op(funct3_csrrw, csr_addr_mip, 5'd2, 32'h0);
    csr_op(funct3_csrrwi, csr_addr_mstatus, 5'd0, 32'h0);
    read_csr(csr_addr_mip);
    finish_test();

    start_test("barrier");
    barsend_i = 1'b1;
    @(negedge clk_i);
    barsend_i = 1'b0;
    model_pi  = model_pi ^ 32'h1;
    check_value("pi toggle", model_pi, {31'b0, barrier_pi_o});
    csr_op(funct3_csrrw, csr_addr_barcfg, 5'd2, 32'h0005_0055);
    @(negedge clk_i);
    check_value("src out", 32'h55, {25'b0, barrier_src_o});
    check_value("dest out", 32'h5, {29'b0, barrier_dest_o});
    read_csr(csr_addr_barcfg);
    csr_op(funct3_csrrw, csr_addr_credit_limit, 5'd2, $urandom);
    read_csr(csr_addr_credit_limit);
    barrier_po_i = 1'b1;
    read_csr(csr_addr_bar_po);
    finish_test();

    $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== csr_top_asserts.sv ====
// concurrent checks on the trap and rd handshake of csr_top that are attached by bind
`timescale 1ns/1ps
`default_nettype none

module csr_top_asserts (
  input wire logic        clk_i,
  input wire logic        reset_i,
  input wire logic        instr_v_i,
  input wire logic [31:0] instr_i,
  input wire logic        trap_o,
  input wire logic        rd_v_o,
  input wire logic        mstatus_mie
);

  import csr_pkg::*;

  logic csr_accepted;

  // same acceptance rule as the EXE register
  assign csr_accepted = instr_v_i & ~trap_o & (instr_i[6:0] == opcode_system) &
                        (instr_i[14:12] != 3'b000);

  // trap entry needs MIE and clears it at the next edge
  trap_needs_mie: assert property (@(posedge clk_i) disable iff (reset_i)
    trap_o |-> mstatus_mie ##1 !mstatus_mie)
    else $error("trap taken with mstatus.MIE clear or MIE not cleared after the trap");

  rd_follows_csr: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_accepted |=> rd_v_o)
    else $error("rd_v missing one cycle after an accepted CSR instruction");

endmodule

bind csr_top csr_top_asserts asserts (
  .clk_i, .reset_i, .instr_v_i, .instr_i, .trap_o, .rd_v_o, .mstatus_mie
);

`default_nettype wire

// ==== csr_top.sv ====
// top level of the machine CSR subsystem, ties the EXE decode, the CSR file and the trap unit
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
  parameter int  pc_width_p             = 22,
  parameter int  barrier_dirs_p         = 7,
  parameter int  credit_limit_default_p = 32,
  parameter int  credit_counter_width_p = 6,
  localparam int barrier_lg_dirs_lp     = $clog2(barrier_dirs_p + 1)
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset_i,
  input  wire logic                                  instr_v_i,
  input  wire logic [31:0]                           instr_i,
  input  wire logic [pc_width_p-1:0]                 pc_i,
  input  wire logic [csr_pkg::reg_data_width-1:0]    rs1_data_i,
  output logic                                       rd_v_o,
  output logic [csr_pkg::reg_data_width-1:0]         rd_data_o,
  input  wire logic                                  remote_set_i,
  input  wire logic                                  remote_clear_i,
  input  wire logic                                  barsend_i,
  input  wire logic                                  barrier_po_i,
  output logic                                       barrier_pi_o,
  output logic [barrier_dirs_p-1:0]                  barrier_src_o,
  output logic [barrier_lg_dirs_lp-1:0]              barrier_dest_o,
  input  wire logic [31:0]                           cfg_pod_reset_i,
  output logic [31:0]                                cfg_pod_o,
  output logic [credit_counter_width_p-1:0]          credit_limit_o,
  output logic [pc_width_p-1:0]                      mepc_o,
  output logic                                       trap_o,
  output logic [4:0]                                 trap_cause_o,
  output logic [31:0]                                redirect_pc_o
);

  import csr_pkg::*;

  logic                       exe_v;
  logic                       exe_we;
  logic                       exe_mret;
  logic [11:0]                exe_addr;
  logic [2:0]                 exe_funct3;
  logic [reg_data_width-1:0]  exe_data;
  logic [reg_addr_width-1:0]  exe_rs1;
  logic [pc_width_p-1:0]      exe_pc;
  logic                       mstatus_mie;
  logic [1:0]                 mie_bits;
  logic [1:0]                 mip_bits;
  logic                       interrupt_entered;
  logic [pc_width_p-1:0]      npc;

  // the CSR value read in EXE goes back to rd
  assign rd_v_o = exe_we;

  csr_decode #(
    .pc_width_p(pc_width_p)
  ) decode (
    .clk_i, .reset_i, .instr_v_i, .instr_i, .pc_i, .rs1_data_i,
    .flush_i      (trap_o),
    .exe_v_o      (exe_v),
    .exe_we_o     (exe_we),
    .exe_mret_o   (exe_mret),
    .exe_addr_o   (exe_addr),
    .exe_funct3_o (exe_funct3),
    .exe_data_o   (exe_data),
    .exe_rs1_o    (exe_rs1),
    .exe_pc_o     (exe_pc)
  );

  mcsr #(
    .pc_width_p             (pc_width_p),
    .barrier_dirs_p         (barrier_dirs_p),
    .credit_limit_default_p (credit_limit_default_p),
    .credit_counter_width_p (credit_counter_width_p)
  ) csr (
    .clk_i, .reset_i, .remote_set_i, .remote_clear_i,
    .we_i                (exe_we),
    .addr_i              (exe_addr),
    .funct3_i            (exe_funct3),
    .data_i              (exe_data),
    .rs1_i               (exe_rs1),
    .instr_executed_i    (exe_v),
    .interrupt_entered_i (interrupt_entered),
    .mret_i              (exe_mret),
    .npc_i               (npc),
    .barsend_i, .barrier_po_i, .cfg_pod_reset_i,
    .data_o              (rd_data_o),
    .mstatus_mie_o       (mstatus_mie),
    .mie_o               (mie_bits),
    .mip_o               (mip_bits),
    .mepc_o, .credit_limit_o, .cfg_pod_o,
    .barrier_src_o, .barrier_dest_o, .barrier_pi_o
  );

  trap_unit #(
    .pc_width_p(pc_width_p)
  ) trap (
    .clk_i, .reset_i,
    .mstatus_mie_i       (mstatus_mie),
    .mie_i               (mie_bits),
    .mip_i               (mip_bits),
    .exe_v_i             (exe_v),
    .exe_we_i            (exe_we),
    .exe_mret_i          (exe_mret),
    .exe_pc_i            (exe_pc),
    .interrupt_entered_o (interrupt_entered),
    .npc_o               (npc),
    .trap_o, .trap_cause_o, .redirect_pc_o
  );

endmodule

`default_nettype wire

// ==== trap_unit.sv ====
// interrupt trap unit, decides when to take an interrupt and redirects the pc to its handler
`timescale 1ns/1ps
`default_nettype none

module trap_unit #(
  parameter int pc_width_p = 22
) (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   mstatus_mie_i,
  input  wire logic [1:0]             mie_i,
  input  wire logic [1:0]             mip_i,
  input  wire logic                   exe_v_i,
  input  wire logic                   exe_we_i,
  input  wire logic                   exe_mret_i,
  input  wire logic [pc_width_p-1:0]  exe_pc_i,
  output logic                        interrupt_entered_o,
  output logic [pc_width_p-1:0]       npc_o,
  output logic                        trap_o,
  output logic [4:0]                  trap_cause_o,
  output logic [31:0]                 redirect_pc_o
);

  import csr_pkg::*;

  logic [1:0]            pending;
  logic                  remote_pending;
  logic                  take;
  logic [pc_width_p-1:0] exe_pc_next;
  logic [pc_width_p-1:0] npc_r;

  // bit 1 trace, bit 0 remote
  assign pending        = mie_i & mip_i;
  assign remote_pending = pending[0];

  // mret or a CSR write in EXE could change the enables this cycle
  assign take = mstatus_mie_i & (|pending) & ~exe_mret_i & ~exe_we_i;

  assign trap_o              = take;
  assign interrupt_entered_o = take;

  // cause code is the interrupt's bit index, remote first
  assign trap_cause_o  = remote_pending ? 5'(irq_remote_bit) : 5'(irq_trace_bit);
  assign redirect_pc_o = remote_pending ? trap_vec_remote : trap_vec_trace;

  assign exe_pc_next = exe_pc_i + pc_width_p'(1);

  // pc of the next instruction to execute
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      npc_r <= '0;
    end else if (take) begin
      npc_r <= redirect_pc_o[2+:pc_width_p];
    end else if (exe_v_i) begin
      npc_r <= exe_pc_next;
    end
  end

  // the instruction in EXE completes before the trap
  assign npc_o = exe_v_i ? exe_pc_next : npc_r;

endmodule

`default_nettype wire

// ==== mcsr.sv ====
// machine CSR register file of the tile, written from EXE and read back through the read mux
`timescale 1ns/1ps
`default_nettype none

module mcsr #(
  parameter int  pc_width_p             = 22,
  parameter int  barrier_dirs_p         = 7,
  parameter int  credit_limit_default_p = 32,
  parameter int  credit_counter_width_p = 6,
  localparam int barrier_lg_dirs_lp     = $clog2(barrier_dirs_p + 1)
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset_i,
  input  wire logic                                  remote_set_i,
  input  wire logic                                  remote_clear_i,
  input  wire logic                                  we_i,
  input  wire logic [11:0]                           addr_i,
  input  wire logic [2:0]                            funct3_i,
  input  wire logic [csr_pkg::reg_data_width-1:0]    data_i,
  input  wire logic [csr_pkg::reg_addr_width-1:0]    rs1_i,
  input  wire logic                                  instr_executed_i,
  input  wire logic                                  interrupt_entered_i,
  input  wire logic                                  mret_i,
  input  wire logic [pc_width_p-1:0]                 npc_i,
  input  wire logic                                  barsend_i,
  input  wire logic                                  barrier_po_i,
  input  wire logic [31:0]                           cfg_pod_reset_i,
  output logic [csr_pkg::reg_data_width-1:0]         data_o,
  output logic                                       mstatus_mie_o,
  output logic [1:0]                                 mie_o,
  output logic [1:0]                                 mip_o,
  output logic [pc_width_p-1:0]                      mepc_o,
  output logic [credit_counter_width_p-1:0]          credit_limit_o,
  output logic [31:0]                                cfg_pod_o,
  output logic [barrier_dirs_p-1:0]                  barrier_src_o,
  output logic [barrier_lg_dirs_lp-1:0]              barrier_dest_o,
  output logic                                       barrier_pi_o
);

  import csr_pkg::*;

  // bit 1 is trace, bit 0 is remote in mie_r and mip_r
  logic                       mstatus_mpie_r;
  logic                       mstatus_mie_r;
  logic [1:0]                 mie_r;
  logic [1:0]                 mip_r;
  logic [reg_data_width-1:0]  imm_word;
  logic [reg_data_width-1:0]  wr_word;
  logic                       imm_form;
  logic                       wr_any;
  logic                       wr_reg;
  logic                       wr_rw;

  // read mux, also the old value for set and clear
  always_comb begin
    data_o = '0;
    case (addr_i)
      csr_addr_mstatus: begin
        data_o[mstatus_mie_bit]  = mstatus_mie_r;
        data_o[mstatus_mpie_bit] = mstatus_mpie_r;
      end
      csr_addr_mie: begin
        data_o[irq_trace_bit]  = mie_r[1];
        data_o[irq_remote_bit] = mie_r[0];
      end
      csr_addr_mip: begin
        data_o[irq_trace_bit]  = mip_r[1];
        data_o[irq_remote_bit] = mip_r[0];
      end
      csr_addr_mepc:         data_o[2+:pc_width_p] = mepc_o;
      csr_addr_credit_limit: data_o[0+:credit_counter_width_p] = credit_limit_o;
      csr_addr_cfg_pod:      data_o = cfg_pod_o;
      csr_addr_barcfg: begin
        data_o[0+:barrier_dirs_p]      = barrier_src_o;
        data_o[16+:barrier_lg_dirs_lp] = barrier_dest_o;
      end
      csr_addr_bar_pi:       data_o[0] = barrier_pi_o;
      csr_addr_bar_po:       data_o[0] = barrier_po_i;
      default:               data_o = '0;
    endcase
  end

  // zimm form of rs1
  assign imm_word = {{(reg_data_width - reg_addr_width){1'b0}}, rs1_i};

  // full word after the operation, each register picks its own field
  always_comb begin
    imm_form = 1'b0;
    case (funct3_i)
      funct3_csrrw:  wr_word = data_i;
      funct3_csrrs:  wr_word = data_o | data_i;
      funct3_csrrc:  wr_word = data_o & ~data_i;
      funct3_csrrwi: begin
        wr_word  = imm_word;
        imm_form = 1'b1;
      end
      funct3_csrrsi: begin
        wr_word  = data_o | imm_word;
        imm_form = 1'b1;
      end
      funct3_csrrci: begin
        wr_word  = data_o & ~imm_word;
        imm_form = 1'b1;
      end
      default:       wr_word = data_o;
    endcase
  end

  // which forms each group of registers accepts
  assign wr_any = we_i;
  assign wr_reg = we_i & ~imm_form;
  assign wr_rw  = we_i & (funct3_i == funct3_csrrw);

  // mstatus, mret over interrupt entry over CSR write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mstatus_mie_r  <= 1'b0;
      mstatus_mpie_r <= 1'b0;
    end else if (mret_i) begin
      mstatus_mie_r  <= mstatus_mpie_r;
      mstatus_mpie_r <= 1'b0;
    end else if (interrupt_entered_i) begin
      mstatus_mie_r  <= 1'b0;
      mstatus_mpie_r <= mstatus_mie_r;
    end else if (wr_any && addr_i == csr_addr_mstatus) begin
      mstatus_mie_r  <= wr_word[mstatus_mie_bit];
      mstatus_mpie_r <= wr_word[mstatus_mpie_bit];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mie_r <= 2'b00;
    end else if (wr_reg && addr_i == csr_addr_mie) begin
      mie_r <= {wr_word[irq_trace_bit], wr_word[irq_remote_bit]};
    end
  end

  // mip, hardware events win over the CSR write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mip_r <= 2'b00;
    end else begin
      if (instr_executed_i && mie_r[1]) begin
        mip_r[1] <= 1'b1;
      end else if (wr_reg && addr_i == csr_addr_mip) begin
        mip_r[1] <= wr_word[irq_trace_bit];
      end
      if (remote_set_i) begin
        mip_r[0] <= 1'b1;
      end else if (remote_clear_i) begin
        mip_r[0] <= 1'b0;
      end else if (wr_reg && addr_i == csr_addr_mip) begin
        mip_r[0] <= wr_word[irq_remote_bit];
      end
    end
  end

  // mepc holds a word address
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mepc_o <= '0;
    end else if (interrupt_entered_i) begin
      mepc_o <= npc_i;
    end else if (wr_reg && addr_i == csr_addr_mepc) begin
      mepc_o <= wr_word[2+:pc_width_p];
    end
  end

  // tile configuration, csrrw only
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_limit_o <= credit_counter_width_p'(credit_limit_default_p);
      cfg_pod_o      <= cfg_pod_reset_i;
      barrier_src_o  <= '0;
      barrier_dest_o <= '0;
    end else if (wr_rw) begin
      if (addr_i == csr_addr_credit_limit) begin
        credit_limit_o <= wr_word[0+:credit_counter_width_p];
      end
      if (addr_i == csr_addr_cfg_pod) begin
        cfg_pod_o <= wr_word;
      end
      if (addr_i == csr_addr_barcfg) begin
        barrier_src_o  <= wr_word[0+:barrier_dirs_p];
        barrier_dest_o <= wr_word[16+:barrier_lg_dirs_lp];
      end
    end
  end

  // barrier Pi bit, a CSR write suppresses the barsend toggle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      barrier_pi_o <= 1'b0;
    end else if (wr_any && addr_i == csr_addr_bar_pi) begin
      barrier_pi_o <= wr_word[0];
    end else if (barsend_i) begin
      barrier_pi_o <= ~barrier_pi_o;
    end
  end

  assign mstatus_mie_o = mstatus_mie_r;
  assign mie_o         = mie_r;
  assign mip_o         = mip_r;

endmodule

`default_nettype wire

// ==== csr_decode.sv ====
// decodes a SYSTEM instruction word and holds the CSR operation in the EXE register for mcsr
`timescale 1ns/1ps
`default_nettype none

module csr_decode #(
  parameter int pc_width_p = 22
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   reset_i,
  input  wire logic                                   instr_v_i,
  input  wire logic [31:0]                            instr_i,
  input  wire logic [pc_width_p-1:0]                  pc_i,
  input  wire logic [csr_pkg::reg_data_width-1:0]     rs1_data_i,
  input  wire logic                                   flush_i,
  output logic                                        exe_v_o,
  output logic                                        exe_we_o,
  output logic                                        exe_mret_o,
  output logic [11:0]                                 exe_addr_o,
  output logic [2:0]                                  exe_funct3_o,
  output logic [csr_pkg::reg_data_width-1:0]          exe_data_o,
  output logic [csr_pkg::reg_addr_width-1:0]          exe_rs1_o,
  output logic [pc_width_p-1:0]                       exe_pc_o
);

  import csr_pkg::*;

  logic accept;
  logic is_system;
  logic is_csr;
  logic is_mret;

  // an instruction arriving with the trap is lost
  assign accept = instr_v_i & ~flush_i;

  assign is_system = (instr_i[6:0] == opcode_system);
  // funct3 of zero is ecall, ebreak, mret and friends
  assign is_csr    = is_system & (instr_i[14:12] != 3'b000);
  assign is_mret   = (instr_i == instr_mret);

  // valid bits of the EXE register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_v_o    <= 1'b0;
      exe_we_o   <= 1'b0;
      exe_mret_o <= 1'b0;
    end else begin
      exe_v_o    <= accept;
      exe_we_o   <= accept & is_csr;
      exe_mret_o <= accept & is_mret;
    end
  end

  // operand fields, only meaningful alongside the valid bits
  always_ff @(posedge clk_i) begin
    if (accept) begin
      exe_addr_o   <= instr_i[31:20];
      exe_funct3_o <= instr_i[14:12];
      exe_rs1_o    <= instr_i[19:15];
      exe_data_o   <= rs1_data_i;
      exe_pc_o     <= pc_i;
    end
  end

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
// shared CSR addresses, instruction encodings and field positions, imported by the CSR modules
`default_nettype none

package csr_pkg;

  localparam int reg_data_width = 32;
  localparam int reg_addr_width = 5;

  // standard machine CSRs
  localparam logic [11:0] csr_addr_mstatus = 12'h300;
  localparam logic [11:0] csr_addr_mie     = 12'h304;
  localparam logic [11:0] csr_addr_mepc    = 12'h341;
  localparam logic [11:0] csr_addr_mip     = 12'h344;

  // custom tile CSRs
  localparam logic [11:0] csr_addr_cfg_pod      = 12'h360;
  localparam logic [11:0] csr_addr_credit_limit = 12'hfc0;
  localparam logic [11:0] csr_addr_barcfg       = 12'hfc1;
  localparam logic [11:0] csr_addr_bar_pi       = 12'hfc2;
  localparam logic [11:0] csr_addr_bar_po       = 12'hfc3;

  // funct3 of the SYSTEM opcode
  localparam logic [2:0] funct3_csrrw  = 3'b001;
  localparam logic [2:0] funct3_csrrs  = 3'b010;
  localparam logic [2:0] funct3_csrrc  = 3'b011;
  localparam logic [2:0] funct3_csrrwi = 3'b101;
  localparam logic [2:0] funct3_csrrsi = 3'b110;
  localparam logic [2:0] funct3_csrrci = 3'b111;

  localparam logic [6:0]  opcode_system = 7'b1110011;
  localparam logic [31:0] instr_mret    = 32'h3020_0073;

  // mstatus fields
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;

  // interrupt bits in the mie and mip words
  localparam int irq_remote_bit = 16;
  localparam int irq_trace_bit  = 17;

  // byte addresses of the interrupt handlers
  localparam logic [31:0] trap_vec_remote = 32'h0000_0004;
  localparam logic [31:0] trap_vec_trace  = 32'h0000_0008;

endpackage

`default_nettype wire
